/* include/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// fetch and commit side widths of an RV32 core
`define BP_ADDR_WIDTH 32
`define BP_INSTR_WIDTH 32

// every counter table has 2**BP_PHT_INDEX_WIDTH entries
// the global and the local histories share this width so they can be XORed into an index
`define BP_PHT_INDEX_WIDTH 8

// local history table entries are selected by low PC bits above the halfword bit
`define BP_LBHT_INDEX_WIDTH 4

// gshare, local and chooser
`define BP_NUM_TABLES 3

`endif

/* hw/bp_pkg.sv */
`include "bp_settings.svh"

package bp_pkg;

    // values 2 and 3 predict taken
    typedef logic [1:0] pht_counter_t;

    typedef enum logic [1:0] {
        TBL_GSHARE  = 2'd0,
        TBL_LOCAL   = 2'd1,
        TBL_CHOOSER = 2'd2
    } table_id_e;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'h63,
        OP_JAL    = 7'h6f,
        OP_JALR   = 7'h67
    } opcode_e;

    typedef struct packed {
        logic                      is_branch;
        logic                      is_jal;
        logic                      is_jalr;
        logic                      rd_is_link;
        logic                      rs1_is_link;
        logic                      rd_eq_rs1;
        logic [`BP_ADDR_WIDTH-1:0] imm_b;
        logic [`BP_ADDR_WIDTH-1:0] imm_j;
    } decode_t;

    function automatic decode_t decode_instr(input logic [`BP_INSTR_WIDTH-1:0] instr);
        decode_t    dec;
        logic [4:0] rd;
        logic [4:0] rs1;
        rd  = instr[11:7];
        rs1 = instr[19:15];
        dec.is_branch   = (instr[6:0] == OP_BRANCH);
        dec.is_jal      = (instr[6:0] == OP_JAL);
        dec.is_jalr     = (instr[6:0] == OP_JALR);
        // x1 (ra) and x5 (t0) are the link registers of the calling convention
        dec.rd_is_link  = (rd == 5'd1) || (rd == 5'd5);
        dec.rs1_is_link = (rs1 == 5'd1) || (rs1 == 5'd5);
        dec.rd_eq_rs1   = (rd == rs1);
        dec.imm_b = {{(`BP_ADDR_WIDTH - 13){instr[31]}}, instr[31], instr[7],
                     instr[30:25], instr[11:8], 1'b0};
        dec.imm_j = {{(`BP_ADDR_WIDTH - 21){instr[31]}}, instr[31], instr[19:12],
                     instr[20], instr[30:21], 1'b0};
        return dec;
    endfunction

    // bit 1 is skipped as well since compressed instructions are not predicted
    function automatic logic [`BP_PHT_INDEX_WIDTH-1:0] pc_hash(
        input logic [`BP_ADDR_WIDTH-1:0] pc
    );
        return pc[`BP_PHT_INDEX_WIDTH+1:2];
    endfunction

endpackage

/* hw/table_if.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

interface table_if #(
    parameter int INDEX_WIDTH = `BP_PHT_INDEX_WIDTH
);
    import bp_pkg::*;

    logic [INDEX_WIDTH-1:0] read_index;
    pht_counter_t           read_counter;
    logic                   write_en;
    logic [INDEX_WIDTH-1:0] write_index;
    logic                   write_up;

    modport indexer (
        output read_index,
        output write_en,
        output write_index,
        output write_up
    );

    modport table_side (
        input  read_index,
        input  write_en,
        input  write_index,
        input  write_up,
        output read_counter
    );

    modport reader (
        input read_counter
    );

endinterface

/* hw/counter_table.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

module counter_table #(
    parameter int INDEX_WIDTH = `BP_PHT_INDEX_WIDTH
) (
    input  logic         clk,
    input  logic         rst,
    table_if.table_side  port
);
    import bp_pkg::*;

    localparam int DEPTH = 1 << INDEX_WIDTH;

    pht_counter_t counters [DEPTH];
    pht_counter_t write_old;
    pht_counter_t write_new;

    always_comb begin
        write_old = counters[port.write_index];
        write_new = write_old;
        if (port.write_up) begin
            if (write_old != 2'd3) begin
                write_new = write_old + 2'd1;
            end
        end else if (write_old != 2'd0) begin
            write_new = write_old - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                counters[i] <= 2'd0;
            end
        end else if (port.write_en) begin
            counters[port.write_index] <= write_new;
        end
    end

    // a commit to the entry being fetched is visible in the same cycle
    assign port.read_counter = (port.write_en && (port.write_index == port.read_index)) ?
                               write_new : counters[port.read_index];

    // the write index comes from the commit pc and history, so an X here means a bad commit
    a_write_index_known: assert property (
        @(posedge clk) disable iff (rst)
        port.write_en |-> !$isunknown(port.write_index)
    );

endmodule

/* hw/history_indexer.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

module history_indexer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`BP_ADDR_WIDTH-1:0]  fetch_pc,
    input  logic                       commit_valid,
    input  logic [`BP_ADDR_WIDTH-1:0]  commit_pc,
    input  logic [`BP_INSTR_WIDTH-1:0] commit_instr,
    input  logic                       commit_taken,
    input  logic                       commit_hit,
    input  logic                       commit_use_local,
    table_if.indexer                   tbl [`BP_NUM_TABLES]
);
    import bp_pkg::*;

    localparam int HIST_WIDTH   = `BP_PHT_INDEX_WIDTH;
    localparam int LBHT_ENTRIES = 1 << `BP_LBHT_INDEX_WIDTH;

    logic [HIST_WIDTH-1:0] global_hist;
    logic [HIST_WIDTH-1:0] local_hist [LBHT_ENTRIES];

    decode_t commit_dec;
    logic    commit_branch;

    logic [HIST_WIDTH-1:0]           fetch_hash;
    logic [HIST_WIDTH-1:0]           commit_hash;
    logic [`BP_LBHT_INDEX_WIDTH-1:0] fetch_lbht_index;
    logic [`BP_LBHT_INDEX_WIDTH-1:0] commit_lbht_index;
    logic [HIST_WIDTH-1:0]           fetch_local_hist;
    logic [HIST_WIDTH-1:0]           commit_local_hist;

    logic [HIST_WIDTH-1:0] global_read_index;
    logic [HIST_WIDTH-1:0] global_write_index;
    logic                  chooser_up;

    // only conditional branches train the predictor
    assign commit_dec    = decode_instr(commit_instr);
    assign commit_branch = commit_valid && commit_dec.is_branch;

    assign fetch_hash        = pc_hash(fetch_pc);
    assign commit_hash       = pc_hash(commit_pc);
    assign fetch_lbht_index  = fetch_pc[`BP_LBHT_INDEX_WIDTH+1:2];
    assign commit_lbht_index = commit_pc[`BP_LBHT_INDEX_WIDTH+1:2];
    assign fetch_local_hist  = local_hist[fetch_lbht_index];
    assign commit_local_hist = local_hist[commit_lbht_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            global_hist <= '0;
        end else if (commit_branch) begin
            global_hist <= {global_hist[HIST_WIDTH-2:0], commit_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LBHT_ENTRIES; i++) begin
                local_hist[i] <= '0;
            end
        end else if (commit_branch) begin
            local_hist[commit_lbht_index] <= {commit_local_hist[HIST_WIDTH-2:0], commit_taken};
        end
    end

    // gshare and the chooser see the same index
    assign global_read_index  = global_hist ^ fetch_hash;
    assign global_write_index = global_hist ^ commit_hash;

    // reinforce the table fetch used when it was right, lean to the other one otherwise
    assign chooser_up = commit_hit ? commit_use_local : !commit_use_local;

    assign tbl[TBL_GSHARE].read_index  = global_read_index;
    assign tbl[TBL_GSHARE].write_en    = commit_branch;
    assign tbl[TBL_GSHARE].write_index = global_write_index;
    assign tbl[TBL_GSHARE].write_up    = commit_taken;

    assign tbl[TBL_LOCAL].read_index  = fetch_local_hist ^ fetch_hash;
    assign tbl[TBL_LOCAL].write_en    = commit_branch;
    assign tbl[TBL_LOCAL].write_index = commit_local_hist ^ commit_hash;
    assign tbl[TBL_LOCAL].write_up    = commit_taken;

    assign tbl[TBL_CHOOSER].read_index  = global_read_index;
    assign tbl[TBL_CHOOSER].write_en    = commit_branch;
    assign tbl[TBL_CHOOSER].write_index = global_write_index;
    assign tbl[TBL_CHOOSER].write_up    = chooser_up;

    // a retired instruction decides whether the tables and histories move
    a_commit_instr_known: assert property (
        @(posedge clk) disable iff (rst)
        commit_valid |-> !$isunknown(commit_instr)
    );

endmodule

/* hw/prediction_select.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

module prediction_select (
    input  logic                       fetch_valid,
    input  logic [`BP_ADDR_WIDTH-1:0]  fetch_pc,
    input  logic [`BP_INSTR_WIDTH-1:0] fetch_instr,
    table_if.reader                    tbl [`BP_NUM_TABLES],
    input  logic [`BP_ADDR_WIDTH-1:0]  ras_top_addr,
    output logic                       pred_valid,
    output logic                       pred_taken,
    output logic [`BP_ADDR_WIDTH-1:0]  pred_next_pc,
    output logic                       pred_use_local,
    output logic                       ras_push,
    output logic                       ras_pop,
    output logic [`BP_ADDR_WIDTH-1:0]  ras_push_addr
);
    import bp_pkg::*;

    decode_t      dec;
    pht_counter_t gshare_ctr;
    pht_counter_t local_ctr;
    pht_counter_t chooser_ctr;
    pht_counter_t selected_ctr;
    logic         use_local;
    logic [`BP_ADDR_WIDTH-1:0] seq_pc;

    assign dec = decode_instr(fetch_instr);

    assign gshare_ctr  = tbl[TBL_GSHARE].read_counter;
    assign local_ctr   = tbl[TBL_LOCAL].read_counter;
    assign chooser_ctr = tbl[TBL_CHOOSER].read_counter;

    // the chooser counts toward local when it reaches the upper half
    assign use_local    = (chooser_ctr >= 2'd2);
    assign selected_ctr = use_local ? local_ctr : gshare_ctr;

    assign seq_pc = fetch_pc + `BP_ADDR_WIDTH'(4);

    assign pred_valid     = fetch_valid && (dec.is_branch || dec.is_jal || dec.is_jalr);
    assign pred_use_local = dec.is_branch && use_local;

    always_comb begin
        pred_taken   = 1'b0;
        pred_next_pc = seq_pc;
        if (dec.is_branch) begin
            pred_taken = selected_ctr[1];
            if (selected_ctr[1]) begin
                pred_next_pc = fetch_pc + dec.imm_b;
            end
        end else if (dec.is_jal) begin
            pred_taken   = 1'b1;
            pred_next_pc = fetch_pc + dec.imm_j;
        end else if (dec.is_jalr) begin
            // without a target cache every indirect jump is treated as a return
            pred_taken   = 1'b1;
            pred_next_pc = ras_top_addr;
        end
    end

    // calls push the return address, returns pop it
    // jalr ra, ra is a call only, jalr t0, ra both pops and pushes
    assign ras_push      = fetch_valid && (dec.is_jal || dec.is_jalr) && dec.rd_is_link;
    assign ras_pop       = fetch_valid && dec.is_jalr && dec.rs1_is_link &&
                           (!dec.rd_is_link || !dec.rd_eq_rs1);
    assign ras_push_addr = seq_pc;

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fetch_valid,
    input  logic [`BP_ADDR_WIDTH-1:0]  fetch_pc,
    input  logic [`BP_INSTR_WIDTH-1:0] fetch_instr,
    output logic                       pred_valid,
    output logic                       pred_taken,
    output logic [`BP_ADDR_WIDTH-1:0]  pred_next_pc,
    output logic                       pred_use_local,

    output logic                       ras_push,
    output logic                       ras_pop,
    output logic [`BP_ADDR_WIDTH-1:0]  ras_push_addr,
    input  logic [`BP_ADDR_WIDTH-1:0]  ras_top_addr,

    input  logic                       commit_valid,
    input  logic [`BP_ADDR_WIDTH-1:0]  commit_pc,
    input  logic [`BP_INSTR_WIDTH-1:0] commit_instr,
    input  logic                       commit_taken,
    input  logic                       commit_hit,
    input  logic                       commit_use_local
);
    import bp_pkg::*;

    table_if #(.INDEX_WIDTH(`BP_PHT_INDEX_WIDTH)) tbl_bus [`BP_NUM_TABLES] ();

    history_indexer history_indexer_i (
        .clk              (clk),
        .rst              (rst),
        .fetch_pc         (fetch_pc),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .commit_instr     (commit_instr),
        .commit_taken     (commit_taken),
        .commit_hit       (commit_hit),
        .commit_use_local (commit_use_local),
        .tbl              (tbl_bus)
    );

    for (genvar t = int'(TBL_GSHARE); t <= int'(TBL_CHOOSER); t++) begin : g_table
        counter_table #(
            .INDEX_WIDTH (`BP_PHT_INDEX_WIDTH)
        ) counter_table_i (
            .clk  (clk),
            .rst  (rst),
            .port (tbl_bus[t])
        );
    end

    prediction_select prediction_select_i (
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .tbl            (tbl_bus),
        .ras_top_addr   (ras_top_addr),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_next_pc   (pred_next_pc),
        .pred_use_local (pred_use_local),
        .ras_push       (ras_push),
        .ras_pop        (ras_pop),
        .ras_push_addr  (ras_push_addr)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset is released on a rising edge like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* sim/tb_branch_predictor.sv */
`timescale 1ns/1ps
`include "bp_settings.svh"

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int AW             = `BP_ADDR_WIDTH;
    localparam int IW             = `BP_PHT_INDEX_WIDTH;
    localparam int LW             = `BP_LBHT_INDEX_WIDTH;
    localparam int RESET_CYCLES   = 10;
    localparam int TRAIN_LIMIT    = 40;
    localparam int CHOOSER_LIMIT  = 20;
    localparam int RANDOM_CYCLES  = 400;
    // reset, directed cycles, both training loops, the random mix and two idle cycles per test
    localparam int STIM_CYCLES    = RESET_CYCLES + 9 + 6 + TRAIN_LIMIT + CHOOSER_LIMIT + 2 +
                                    RANDOM_CYCLES + 2 * 6;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
    localparam logic [`BP_INSTR_WIDTH-1:0] NOP = 32'h0000_0013;

    typedef struct packed {
        logic          valid;
        logic          taken;
        logic          use_local;
        logic          push;
        logic          pop;
        logic [AW-1:0] next_pc;
        logic [AW-1:0] push_addr;
    } expect_t;

    logic                       clk;
    logic                       rst;
    logic                       fetch_valid;
    logic [AW-1:0]              fetch_pc;
    logic [`BP_INSTR_WIDTH-1:0] fetch_instr;
    logic [AW-1:0]              ras_top_addr;
    logic                       commit_valid;
    logic [AW-1:0]              commit_pc;
    logic [`BP_INSTR_WIDTH-1:0] commit_instr;
    logic                       commit_taken;
    logic                       commit_hit;
    logic                       commit_use_local;
    logic                       pred_valid;
    logic                       pred_taken;
    logic [AW-1:0]              pred_next_pc;
    logic                       pred_use_local;
    logic                       ras_push;
    logic                       ras_pop;
    logic [AW-1:0]              ras_push_addr;

    // model state follows the DUT one falling edge ahead of its next rising edge
    logic [IW-1:0] ref_ghist;
    logic [IW-1:0] ref_lhist [1 << LW];
    pht_counter_t  ref_ctr [`BP_NUM_TABLES][1 << IW];
    expect_t       expected;

    logic [15:0]   lfsr_state = 16'd1;
    logic [AW-1:0] pc_set [8] = '{32'h1000, 32'h1004, 32'h1010, 32'h1024,
                                  32'h1040, 32'h2008, 32'h2400, 32'h33fc};
    int            cycle_count = 0;
    int            checks = 0;
    int            errors = 0;
    int            test_num = 1;
    int            test_checks = 0;
    int            test_errors = 0;

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    branch_predictor branch_predictor_i (
        .clk              (clk),
        .rst              (rst),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_instr      (fetch_instr),
        .pred_valid       (pred_valid),
        .pred_taken       (pred_taken),
        .pred_next_pc     (pred_next_pc),
        .pred_use_local   (pred_use_local),
        .ras_push         (ras_push),
        .ras_pop          (ras_pop),
        .ras_push_addr    (ras_push_addr),
        .ras_top_addr     (ras_top_addr),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .commit_instr     (commit_instr),
        .commit_taken     (commit_taken),
        .commit_hit       (commit_hit),
        .commit_use_local (commit_use_local)
    );

    // galois lfsr, one step per returned bit
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic random_bit();
        logic [15:0] r;
        r = random_bits(1);
        return r[0];
    endfunction

    function automatic logic [`BP_INSTR_WIDTH-1:0] branch_instr(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [`BP_INSTR_WIDTH-1:0] jal_instr(input logic [4:0] rd,
                                                             input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [`BP_INSTR_WIDTH-1:0] jalr_instr(input logic [4:0] rd,
                                                              input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'h67};
    endfunction

    // x0, ra, t0 or a plain register
    function automatic logic [4:0] random_reg();
        logic [15:0] r;
        r = random_bits(2);
        case (r[1:0])
            2'd0:    return 5'd0;
            2'd1:    return 5'd1;
            2'd2:    return 5'd5;
            default: return 5'd2;
        endcase
    endfunction

    function automatic logic [`BP_INSTR_WIDTH-1:0] random_instr();
        logic [15:0] kind;
        logic [15:0] imm;
        logic [4:0]  rd;
        kind = random_bits(2);
        imm  = random_bits(12);
        rd   = random_reg();
        case (kind[1:0])
            2'd0:    return branch_instr({imm[11:0], 1'b0});
            2'd1:    return jal_instr(rd, {{8{imm[11]}}, imm[11:0], 1'b0});
            2'd2:    return jalr_instr(rd, random_reg());
            default: return NOP;
        endcase
    endfunction

    function automatic pht_counter_t saturate_step(input pht_counter_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic logic commit_trains();
        return commit_valid && (commit_instr[6:0] == OP_BRANCH);
    endfunction

    function automatic logic [IW-1:0] table_index(input table_id_e t, input logic [AW-1:0] pc);
        if (t == TBL_LOCAL) begin
            return ref_lhist[pc[LW+1:2]] ^ pc[IW+1:2];
        end
        return ref_ghist ^ pc[IW+1:2];
    endfunction

    function automatic logic train_up(input table_id_e t);
        if (t == TBL_CHOOSER) begin
            return commit_hit ? commit_use_local : !commit_use_local;
        end
        return commit_taken;
    endfunction

    // a commit to the same entry shows its stepped value in the same cycle
    function automatic pht_counter_t read_table(input table_id_e t);
        logic [IW-1:0] read_idx;
        logic [IW-1:0] write_idx;
        read_idx  = table_index(t, fetch_pc);
        write_idx = table_index(t, commit_pc);
        if (commit_trains() && (write_idx == read_idx)) begin
            return saturate_step(ref_ctr[t][write_idx], train_up(t));
        end
        return ref_ctr[t][read_idx];
    endfunction

    function automatic expect_t reference_predict();
        expect_t       e;
        logic [6:0]    op;
        logic [4:0]    rd;
        logic [4:0]    rs1;
        logic          rd_link;
        logic          rs1_link;
        logic          is_jump;
        pht_counter_t  sel;
        logic [AW-1:0] imm_b;
        logic [AW-1:0] imm_j;
        op       = fetch_instr[6:0];
        rd       = fetch_instr[11:7];
        rs1      = fetch_instr[19:15];
        rd_link  = (rd == 5'd1) || (rd == 5'd5);
        rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);
        is_jump  = (op == OP_JAL) || (op == OP_JALR);
        imm_b = {{(AW - 13){fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                 fetch_instr[30:25], fetch_instr[11:8], 1'b0};
        imm_j = {{(AW - 21){fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                 fetch_instr[20], fetch_instr[30:21], 1'b0};
        e.valid     = fetch_valid && ((op == OP_BRANCH) || is_jump);
        e.use_local = (op == OP_BRANCH) && (read_table(TBL_CHOOSER) >= 2'd2);
        sel         = e.use_local ? read_table(TBL_LOCAL) : read_table(TBL_GSHARE);
        e.push_addr = fetch_pc + AW'(4);
        e.push      = fetch_valid && is_jump && rd_link;
        e.pop       = fetch_valid && (op == OP_JALR) && rs1_link && (!rd_link || (rd != rs1));
        if (op == OP_BRANCH) begin
            e.taken   = sel[1];
            e.next_pc = sel[1] ? fetch_pc + imm_b : e.push_addr;
        end else begin
            e.taken   = is_jump;
            e.next_pc = (op == OP_JAL) ? fetch_pc + imm_j : ras_top_addr;
        end
        return e;
    endfunction

    task automatic reset_model();
        ref_ghist = '0;
        for (int i = 0; i < (1 << LW); i++) begin
            ref_lhist[i] = '0;
        end
        for (int t = 0; t < `BP_NUM_TABLES; t++) begin
            for (int i = 0; i < (1 << IW); i++) begin
                ref_ctr[t][i] = 2'd0;
            end
        end
    endtask

    // tables first, they index with the histories from before this commit
    task automatic apply_commit();
        table_id_e     t;
        logic [IW-1:0] idx;
        logic [LW-1:0] slot;
        if (commit_trains()) begin
            for (int i = 0; i < `BP_NUM_TABLES; i++) begin
                t   = table_id_e'(i);
                idx = table_index(t, commit_pc);
                ref_ctr[t][idx] = saturate_step(ref_ctr[t][idx], train_up(t));
            end
            slot            = commit_pc[LW+1:2];
            ref_lhist[slot] = {ref_lhist[slot][IW-2:0], commit_taken};
            ref_ghist       = {ref_ghist[IW-2:0], commit_taken};
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pred_valid: got %h expected %h at pc %h", got, exp, fetch_pc);
        end
    endtask

    task automatic compare_taken(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pred_taken: got %h expected %h at pc %h", got, exp, fetch_pc);
        end
    endtask

    task automatic compare_pc(input logic [AW-1:0] got, input logic [AW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pred_next_pc: got %h expected %h at pc %h", got, exp, fetch_pc);
        end
    endtask

    task automatic compare_counter_choice(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pred_use_local: got %h expected %h at pc %h", got, exp, fetch_pc);
        end
    endtask

    task automatic compare_ras(input logic got_push, input logic got_pop,
                               input logic [AW-1:0] got_addr, input expect_t exp);
        checks++;
        if (got_push !== exp.push) begin
            errors++;
            $display("ERROR ras_push: got %h expected %h at pc %h", got_push, exp.push, fetch_pc);
        end
        if (got_pop !== exp.pop) begin
            errors++;
            $display("ERROR ras_pop: got %h expected %h at pc %h", got_pop, exp.pop, fetch_pc);
        end
        if (got_addr !== exp.push_addr) begin
            errors++;
            $display("ERROR ras_push_addr: got %h expected %h", got_addr, exp.push_addr);
        end
    endtask

    // outputs are combinational, so they are settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            expected = reference_predict();
            compare_valid(pred_valid, expected.valid);
            compare_ras(ras_push, ras_pop, ras_push_addr, expected);
            if (expected.valid) begin
                compare_taken(pred_taken, expected.taken);
                compare_pc(pred_next_pc, expected.next_pc);
                compare_counter_choice(pred_use_local, expected.use_local);
            end
            apply_commit();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic drive_cycle(
        input logic                       fv,
        input logic [AW-1:0]              fpc,
        input logic [`BP_INSTR_WIDTH-1:0] finstr,
        input logic                       cv,
        input logic [AW-1:0]              cpc,
        input logic [`BP_INSTR_WIDTH-1:0] cinstr,
        input logic                       ctaken,
        input logic                       chit,
        input logic                       cuse
    );
        @(posedge clk);
        fetch_valid      <= fv;
        fetch_pc         <= fpc;
        fetch_instr      <= finstr;
        commit_valid     <= cv;
        commit_pc        <= cpc;
        commit_instr     <= cinstr;
        commit_taken     <= ctaken;
        commit_hit       <= chit;
        commit_use_local <= cuse;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        fetch_valid  <= 1'b0;
        commit_valid <= 1'b0;
        @(posedge clk);
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - test_checks, errors - test_errors);
        test_num++;
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        logic [`BP_INSTR_WIDTH-1:0] br;
        logic [`BP_INSTR_WIDTH-1:0] fi;
        logic [`BP_INSTR_WIDTH-1:0] ci;
        logic [15:0]                sel;
        logic [AW-1:0]              fp;
        logic                       fv;
        logic                       cv;
        int                         n;
        fetch_valid      <= 1'b0;
        fetch_pc         <= '0;
        fetch_instr      <= NOP;
        ras_top_addr     <= 32'h0000_8000;
        commit_valid     <= 1'b0;
        commit_pc        <= '0;
        commit_instr     <= NOP;
        commit_taken     <= 1'b0;
        commit_hit       <= 1'b0;
        commit_use_local <= 1'b0;
        while (rst !== 1'b0) begin
            @(posedge clk);
        end

        br = branch_instr(13'h0040);
        for (int k = 0; k < 8; k++) begin
            drive_cycle(1'b1, pc_set[k], br, 1'b0, '0, NOP, 1'b0, 1'b0, 1'b0);
        end
        drive_cycle(1'b1, pc_set[0], NOP, 1'b0, '0, NOP, 1'b0, 1'b0, 1'b0);
        finish_test("fresh branches predict not-taken");

        ras_top_addr <= 32'h0000_3a80;
        drive_cycle(1'b1, pc_set[1], jal_instr(5'd1, 21'h000100), 1'b0, '0, NOP, 0, 0, 0);
        drive_cycle(1'b1, pc_set[2], jal_instr(5'd0, 21'h1ffff0), 1'b0, '0, NOP, 0, 0, 0);
        drive_cycle(1'b1, pc_set[3], jalr_instr(5'd0, 5'd1), 1'b0, '0, NOP, 0, 0, 0);
        drive_cycle(1'b1, pc_set[4], jalr_instr(5'd1, 5'd1), 1'b0, '0, NOP, 0, 0, 0);
        drive_cycle(1'b1, pc_set[5], jalr_instr(5'd5, 5'd1), 1'b0, '0, NOP, 0, 0, 0);
        drive_cycle(1'b1, pc_set[6], jalr_instr(5'd2, 5'd2), 1'b0, '0, NOP, 0, 0, 0);
        finish_test("jal targets and return stack strobes");

        // the global history fills with ones, then the gshare counter climbs
        br = branch_instr(13'h1f00);
        n  = 0;
        do begin
            drive_cycle(1'b1, pc_set[2], br, 1'b1, pc_set[2], br, 1'b1, 1'b1, 1'b0);
            @(negedge clk);
            #1;
            n++;
        end while (!expected.taken && (n < TRAIN_LIMIT));
        if (!expected.taken) begin
            errors++;
            $display("branch never turned taken within %0d commits", TRAIN_LIMIT);
        end
        finish_test("taken commits train the branch taken");

        n = 0;
        do begin
            drive_cycle(1'b1, pc_set[2], br, 1'b1, pc_set[2], br, 1'b1, 1'b0, 1'b0);
            @(negedge clk);
            #1;
            n++;
        end while (!expected.use_local && (n < CHOOSER_LIMIT));
        if (!expected.use_local) begin
            errors++;
            $display("chooser never moved to the local table within %0d commits", CHOOSER_LIMIT);
        end
        finish_test("gshare misses move the chooser");

        // first commit takes the counter to 1, the second one is forwarded to 2
        drive_cycle(1'b0, '0, NOP, 1'b1, pc_set[5], br, 1'b1, 1'b1, 1'b0);
        drive_cycle(1'b1, pc_set[5], br, 1'b1, pc_set[5], br, 1'b1, 1'b1, 1'b0);
        @(negedge clk);
        #1;
        compare_taken(pred_taken, 1'b1);
        finish_test("same-cycle commit is forwarded");

        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            fv  = random_bit();
            sel = random_bits(3);
            fp  = pc_set[sel[2:0]];
            fi  = random_instr();
            cv  = random_bit();
            sel = random_bits(3);
            ci  = random_bit() ? branch_instr(13'h0010) : random_instr();
            drive_cycle(fv, fp, fi, cv, pc_set[sel[2:0]], ci,
                        random_bit(), random_bit(), random_bit());
            sel = random_bits(8);
            ras_top_addr <= AW'({sel[7:0], 2'b00});
        end
        finish_test("random fetch and commit mix");

        $display("tests %0d, checks %0d, errors %0d", test_num - 1, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hw/bp_pkg.sv
hw/table_if.sv
hw/counter_table.sv
hw/history_indexer.sv
hw/prediction_select.sv
hw/branch_predictor.sv
sim/tb_clock.sv
sim/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bp_pkg.sv
      - hw/table_if.sv
      - hw/counter_table.sv
      - hw/history_indexer.sv
      - hw/prediction_select.sv
      - hw/branch_predictor.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock.sv
      - sim/tb_branch_predictor.sv
